// ==== data_memory.sv ====
// ========================================
// Data memory
// Address latch and 128-byte storage
// ========================================

module data_memory
   import spi_memory_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  addr_we,
   input  logic                  mem_we,
   input  logic [addr_width-1:0] addr_in,
   input  logic [data_width-1:0] write_data,
   output logic [data_width-1:0] read_data
);

   logic [addr_width-1:0] addr_reg;
   logic [data_width-1:0] mem [mem_depth];

   always_ff @(posedge clk) begin
      if (reset) begin
         addr_reg <= '0;
         for (int i = 0; i < mem_depth; i++) begin
            mem[i] <= '0;                       // Memory reads back zeros after reset
         end
      end else begin
         if (addr_we) begin
            addr_reg <= addr_in;
         end
         if (mem_we) begin
            mem[addr_reg] <= write_data;
         end
      end
   end

   assign read_data = mem[addr_reg];            // Combinational read at the latched address

endmodule

// ==== filelist.f ====
spi_memory_pkg.sv
input_conditioner.sv
shift_register.sv
data_memory.sv
spi_fsm.sv
spi_memory.sv
spi_memory_sva.sv
spi_memory_tb.sv

// ==== input_conditioner.sv ====
// ========================================
// Input conditioner
// Brings one asynchronous pin into the clk
// domain and gives one-cycle edge pulses
// ========================================

module input_conditioner
   import spi_memory_pkg::*;
#(
   parameter logic idle_level = 1'b0            // Level the pin rests at after reset
) (
   input  logic clk,
   input  logic reset,
   input  logic pin,
   output logic sync,
   output logic rise,
   output logic fall
);

   logic [sync_stages-1:0] sync_chain;          // Metastability filter
   logic                   delayed;             // One more copy for edge detection

   // ========================================
   // Synchronizer and edge detect
   // ========================================
   always_ff @(posedge clk) begin
      if (reset) begin
         sync_chain <= {sync_stages{idle_level}};
         delayed <= idle_level;
         rise <= 1'b0;
         fall <= 1'b0;
      end else begin
         sync_chain <= {sync_chain[sync_stages-2:0], pin};
         delayed <= sync_chain[sync_stages-1];
         // Pulses are registered so they line up with the delayed level
         rise <= sync_chain[sync_stages-1] & ~delayed;
         fall <= ~sync_chain[sync_stages-1] & delayed;
      end
   end

   assign sync = delayed;                       // Same cycle as the edge pulses

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=spi_memory_tb_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module spi_memory_tb -o "$sim_bin"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "STATUS: PASS" "$log_file"; then
   echo "Simulation ended without a status line"
   exit 1
fi
exit 0

// ==== shift_register.sv ====
// ========================================
// Byte shift register
// Serial in on the command and write bytes,
// parallel load and serial out on reads
// ========================================

module shift_register
   import spi_memory_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  serial_in,
   input  logic                  sr_shift,
   input  logic                  sr_out_shift,
   input  logic                  sr_load,
   input  logic [data_width-1:0] load_data,
   output logic [data_width-1:0] parallel_out,
   output logic                  serial_out
);

   logic [data_width-1:0] shift_reg;

   always_ff @(posedge clk) begin
      if (reset) begin
         shift_reg <= '0;
      end else if (sr_load) begin
         shift_reg <= load_data;                // Load wins over both shifts
      end else if (sr_shift) begin
         shift_reg <= {shift_reg[data_width-2:0], serial_in};
      end else if (sr_out_shift) begin
         shift_reg <= {shift_reg[data_width-2:0], 1'b0};  // Next bit moves to the top
      end
   end

   assign parallel_out = shift_reg;
   assign serial_out = shift_reg[data_width-1];  // MSB first on miso

endmodule

// ==== spi_fsm.sv ====
// ========================================
// SPI transaction controller
// Counts sclk edges and sequences address
// latch, memory write and miso enable
// ========================================

module spi_fsm
   import spi_memory_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic cs_rise,
   input  logic cs_fall,
   input  logic sclk_rise,
   input  logic sclk_fall,
   input  logic rw_bit,
   output logic sr_shift,
   output logic sr_out_shift,
   output logic sr_load,
   output logic addr_we,
   output logic mem_we,
   output logic miso_en
);

   fsm_state_t                 state;
   logic [bit_count_width-1:0] bit_cnt;
   logic                       byte_done;

   // Command byte is address plus one direction bit, same length as a data byte
   assign byte_done = (bit_cnt == bit_count_width'(addr_width + 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
         bit_cnt <= '0;
         sr_shift <= 1'b0;
         sr_out_shift <= 1'b0;
         sr_load <= 1'b0;
         addr_we <= 1'b0;
         mem_we <= 1'b0;
         miso_en <= 1'b0;
      end else begin
         sr_shift <= 1'b0;                      // Strobes last one cycle
         sr_out_shift <= 1'b0;
         sr_load <= 1'b0;
         addr_we <= 1'b0;
         mem_we <= 1'b0;

         if (cs_rise) begin
            // Host ended the transaction, drop whatever was in progress
            state <= idle;
            bit_cnt <= '0;
            miso_en <= 1'b0;
         end else begin
            case (state)
               idle: begin
                  if (cs_fall) begin
                     state <= get_cmd;
                     bit_cnt <= '0;
                  end
               end
               get_cmd: begin
                  if (byte_done) begin           // Last shift has landed
                     state <= latch_addr;
                     addr_we <= 1'b1;
                     bit_cnt <= '0;
                  end else if (sclk_rise) begin
                     sr_shift <= 1'b1;
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
               latch_addr: begin
                  if (rw_bit) begin
                     state <= read_load;
                     sr_load <= 1'b1;            // Address is latched by now
                  end else begin
                     state <= write_shift;
                  end
               end
               read_load: begin
                  state <= read_shift;
                  miso_en <= 1'b1;               // MSB is on miso from here
               end
               read_shift: begin
                  if (byte_done) begin
                     state <= done;
                     miso_en <= 1'b0;
                     bit_cnt <= '0;
                  end else begin
                     if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                     // The fall closing the command byte must not shift
                     if (sclk_fall && bit_cnt != '0) begin
                        sr_out_shift <= 1'b1;
                     end
                  end
               end
               write_shift: begin
                  if (byte_done) begin
                     state <= write_mem;
                     mem_we <= 1'b1;
                     bit_cnt <= '0;
                  end else if (sclk_rise) begin
                     sr_shift <= 1'b1;
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
               write_mem: state <= done;
               done: state <= done;              // Only cs rise leaves
               default: state <= idle;
            endcase
         end
      end
   end

endmodule

// ==== spi_memory.sv ====
// ========================================
// SPI byte memory, top level
// Pin conditioners, shift register, memory
// and the transaction controller
// ========================================

module spi_memory
   import spi_memory_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic cs_n,
   input  logic sclk,
   input  logic mosi,
   output logic miso,
   output logic miso_en
);

   logic                  cs_rise, cs_fall;
   logic                  sclk_rise, sclk_fall;
   logic                  mosi_sync;
   logic                  sr_shift, sr_out_shift, sr_load;
   logic                  addr_we, mem_we;
   logic [data_width-1:0] parallel_out;
   logic [data_width-1:0] read_data;

   // ========================================
   // Pin conditioning
   // ========================================
   input_conditioner #(.idle_level(cs_idle_level)) cs_cond_inst (
      .clk(clk), .reset(reset), .pin(cs_n),
      .sync(), .rise(cs_rise), .fall(cs_fall)
   );

   input_conditioner #(.idle_level(sclk_idle_level)) sclk_cond_inst (
      .clk(clk), .reset(reset), .pin(sclk),
      .sync(), .rise(sclk_rise), .fall(sclk_fall)
   );

   input_conditioner #(.idle_level(mosi_idle_level)) mosi_cond_inst (
      .clk(clk), .reset(reset), .pin(mosi),
      .sync(mosi_sync), .rise(), .fall()          // Only the level is sampled
   );

   // ========================================
   // Data path and control
   // ========================================
   shift_register shift_register_inst (
      .clk(clk), .reset(reset), .serial_in(mosi_sync),
      .sr_shift(sr_shift), .sr_out_shift(sr_out_shift), .sr_load(sr_load),
      .load_data(read_data), .parallel_out(parallel_out), .serial_out(miso)
   );

   data_memory data_memory_inst (
      .clk(clk), .reset(reset), .addr_we(addr_we), .mem_we(mem_we),
      .addr_in(parallel_out[data_width-1:1]),     // Upper seven bits are the address
      .write_data(parallel_out), .read_data(read_data)
   );

   spi_fsm spi_fsm_inst (
      .clk(clk), .reset(reset),
      .cs_rise(cs_rise), .cs_fall(cs_fall),
      .sclk_rise(sclk_rise), .sclk_fall(sclk_fall),
      .rw_bit(parallel_out[0]),
      .sr_shift(sr_shift), .sr_out_shift(sr_out_shift), .sr_load(sr_load),
      .addr_we(addr_we), .mem_we(mem_we), .miso_en(miso_en)
   );

endmodule

// ==== spi_memory_pkg.sv ====
// ========================================
// SPI byte memory shared definitions
// Widths, depths, pin idle levels and the
// controller state encoding
// ========================================

package spi_memory_pkg;

   // ========================================
   // Data path sizes
   // ========================================
   localparam int addr_width = 7;               // Address bits in the command byte
   localparam int data_width = 8;               // One SPI byte
   localparam int mem_depth = 128;              // Number of stored bytes

   // ========================================
   // Pin conditioning
   // ========================================
   localparam int sync_stages = 2;              // Synchronizer flip-flops per pin
   localparam logic cs_idle_level = 1'b1;       // Chip select rests high
   localparam logic sclk_idle_level = 1'b0;     // Mode 0 clock rests low
   localparam logic mosi_idle_level = 1'b0;

   // ========================================
   // Controller
   // ========================================
   localparam int bit_count_width = 4;          // Counts 0 to 8

   typedef enum logic [2:0] {
      idle        = 3'd0,                       // Waiting for chip select
      get_cmd     = 3'd1,                       // Receiving address and read/write bit
      latch_addr  = 3'd2,                       // Address capture and direction decode
      read_load   = 3'd3,                       // Memory byte goes into the shift register
      read_shift  = 3'd4,                       // Byte goes out on miso
      write_shift = 3'd5,                       // Receiving the write byte
      write_mem   = 3'd6,                       // Byte is stored
      done        = 3'd7                        // Waiting for chip select to rise
   } fsm_state_t;

endpackage

// ==== spi_memory_stim.txt ====
# op addr data expect abort  (op: w write, r read; addr, data, expect in hex)
# expect is the byte a read must return; abort 1 raises cs_n after 3 data bits of a write
r 00 00 00 0
r 7f 00 00 0
r 2a 00 00 0
w 2a a5 00 0
r 2a 00 a5 0
w 00 3c 00 0
w 7f c3 00 0
w 01 81 00 0
w 40 5a 00 0
r 00 00 3c 0
r 7f 00 c3 0
r 01 00 81 0
r 40 00 5a 0
r 2a 00 a5 0
w 40 ff 00 1
r 40 00 5a 0
w 7f 11 00 1
r 7f 00 c3 0
w 7f 00 00 0
r 7f 00 00 0
w 55 96 00 0
r 55 00 96 0
w 12 01 00 0
w 13 80 00 0
r 12 00 01 0
r 13 00 80 0
w 0f 69 00 0
r 0f 00 69 0
r 10 00 00 0

// ==== spi_memory_sva.sv ====
// ========================================
// SPI controller protocol assertions
// Strobe widths and miso_en rules, bound
// into every spi_fsm instance
// ========================================

module spi_memory_sva
   import spi_memory_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       cs_rise,
   input logic       addr_we,
   input logic       mem_we,
   input logic       miso_en,
   input fsm_state_t state
);
   timeunit 1ns;
   timeprecision 100ps;

   // ========================================
   // Strobes
   // ========================================
   mem_we_one_cycle: assert property (@(posedge clk) disable iff (reset) mem_we |=> !mem_we)
      else $error("mem_we stayed high for more than one clk cycle");

   addr_we_one_cycle: assert property (@(posedge clk) disable iff (reset) addr_we |=> !addr_we)
      else $error("addr_we stayed high for more than one clk cycle");

   // A read never writes the memory
   no_write_on_read: assert property (@(posedge clk) disable iff (reset) !(mem_we && miso_en))
      else $error("mem_we asserted while miso_en was high");

   // ========================================
   // miso_en
   // ========================================
   cs_rise_drops_enable: assert property (@(posedge clk) disable iff (reset)
                                          cs_rise |=> !miso_en)
      else $error("miso_en still high one cycle after a chip select rise");

   enable_only_in_read: assert property (@(posedge clk) disable iff (reset)
                                         miso_en |-> state == read_shift)
      else $error("miso_en high outside the read data phase");

endmodule

bind spi_fsm spi_memory_sva spi_memory_sva_inst (
   .clk(clk), .reset(reset), .cs_rise(cs_rise), .addr_we(addr_we),
   .mem_we(mem_we), .miso_en(miso_en), .state(state)
);

// ==== spi_memory_tb.sv ====
// ========================================
// SPI byte memory testbench
// Acts as SPI mode 0 host, replays the
// stimulus file and checks read data
// ========================================

module spi_memory_tb
   import spi_memory_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int half_clks = 4;                // sclk half period in clk cycles
   localparam int timeout_clks = 64;
   localparam int drive_delay = 10;             // Inputs change this long after clk rises

   logic clk, reset, cs_n, sclk, mosi;
   logic miso, miso_en;
   logic write_active;                          // High for the whole of a write transaction
   logic [data_width-1:0] model [mem_depth];    // Last completed write per address
   int   data_errors, enable_errors, other_errors;
   int   cs_high_clks, txn_count;

   spi_memory spi_memory_inst (
      .clk(clk), .reset(reset), .cs_n(cs_n), .sclk(sclk), .mosi(mosi),
      .miso(miso), .miso_en(miso_en)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ========================================
   // Host tasks
   // ========================================
   task automatic wait_clks(input int n);
      repeat (n) @(posedge clk);
      #drive_delay;
   endtask

   task automatic drive_sclk_bit(input logic mosi_bit, output logic miso_bit,
                                 output logic miso_en_bit);
      mosi = mosi_bit;                          // Set up while sclk is low
      wait_clks(half_clks);
      sclk = 1'b1;
      wait_clks(half_clks);
      miso_bit = miso;                          // Late in the high phase, miso has moved by now
      miso_en_bit = miso_en;
      sclk = 1'b0;
   endtask

   task automatic wait_for_miso_en(output logic seen);
      int cycles;
      cycles = 0;
      while (miso_en !== 1'b1 && cycles < timeout_clks) begin
         wait_clks(1);
         cycles++;
      end
      seen = (miso_en === 1'b1);
      if (!seen) begin
         other_errors++;
         $display("Timeout: miso_en did not rise within %0d clock cycles (time %0t)",
                  timeout_clks, $time);
      end
   endtask

   task automatic run_transaction(input logic [7:0] op, input logic [addr_width-1:0] addr,
                                  input logic [7:0] data, input logic [7:0] expected,
                                  input logic abort);
      logic [7:0] cmd;
      logic [7:0] got;
      logic       bit_in, en_in, seen;
      int         nbits;
      cmd = {addr, op == "r"};                  // Address then read/write bit, MSB first
      got = '0;
      write_active = (op == "w");
      cs_n = 1'b0;
      for (int i = 7; i >= 0; i--) drive_sclk_bit(cmd[i], bit_in, en_in);
      if (op == "w") begin
         nbits = abort ? 3 : 8;                 // Aborted writes stop partway through the byte
         for (int i = 7; i >= 8 - nbits; i--) drive_sclk_bit(data[i], bit_in, en_in);
         if (!abort) model[addr] = data;
      end else begin
         wait_for_miso_en(seen);
         if (seen) begin
            for (int i = 7; i >= 0; i--) begin
               drive_sclk_bit(1'b0, bit_in, en_in);
               got = {got[6:0], bit_in};
               assert (en_in === 1'b1) else begin
                  enable_errors++;
                  $display("FAIL at %0t: miso_en low during read data bit %0d", $time, i);
               end
            end
            assert (got === expected) else begin
               data_errors++;
               $display("FAIL at %0t: read of address %h returned %h, expected %h",
                        $time, addr, got, expected);
            end
            assert (expected === model[addr]) else begin
               other_errors++;
               $display("Stimulus line expects %h at address %h but write history gives %h",
                        expected, addr, model[addr]);
            end
         end
      end
      wait_clks(half_clks);
      cs_n = 1'b1;
      wait_clks(half_clks);                     // Minimum cs_n high time between transactions
      write_active = 1'b0;
      txn_count++;
   endtask

   // ========================================
   // miso_en monitor
   // ========================================
   initial begin
      cs_high_clks = 0;
      forever begin
         @(negedge clk);
         if (cs_n) cs_high_clks++;
         else cs_high_clks = 0;
         // cs rise takes 4 clk to reach the controller
         if (reset || write_active || cs_high_clks > 4) begin
            assert (miso_en === 1'b0) else begin
               enable_errors++;
               $display("FAIL at %0t: miso_en high while it must be low", $time);
            end
         end
      end
   end

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      int         fd, fields, status;
      string      line;
      logic [7:0] op, data, expected;
      logic [addr_width-1:0] addr;
      logic [3:0] abort_flag;
      reset = 1'b1;
      cs_n = 1'b1;
      sclk = 1'b0;
      mosi = 1'b0;
      write_active = 1'b0;
      data_errors = 0;
      enable_errors = 0;
      other_errors = 0;
      txn_count = 0;
      for (int i = 0; i < mem_depth; i++) model[i] = '0;   // Memory reads zero after reset
      wait_clks(5);
      reset = 1'b0;
      wait_clks(half_clks);
      fd = $fopen("spi_memory_stim.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Could not open the stimulus file spi_memory_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            status = $fgets(line, fd);
            if (status > 0 && line.len() > 1 && line[0] != "#") begin
               fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, expected, abort_flag);
               if (fields != 5 || (op != "r" && op != "w")) begin
                  other_errors++;
                  $display("Could not parse stimulus line: %s", line);
               end else begin
                  run_transaction(op, addr, data, expected, abort_flag != 0);
               end
            end
         end
         $fclose(fd);
      end
      if (txn_count == 0) begin
         other_errors++;
         $display("No transactions were run");
      end
      wait_clks(8);
      $display("Error counts: data %0d, miso_en %0d, other %0d over %0d transactions",
               data_errors, enable_errors, other_errors, txn_count);
      if (data_errors + enable_errors + other_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
